// File: Bender.yml
package:
  name: fm_accum

sources:
  - files:
      - verilog/cnn_cfg_pkg.sv
      - verilog/fm_op_pkg.sv
      - verilog/fm_cmd_if.sv
      - verilog/fp16_add.sv
      - verilog/fm_cmd_decode.sv
      - verilog/fm_accum_exec.sv
      - verilog/fm_read_result.sv
      - verilog/fm_accum_top.sv
  - target: simulation
    files:
      - sim/fm_accum_sva.sv
      - sim/fm_accum_tb.sv

// File: project.f
verilog/cnn_cfg_pkg.sv
verilog/fm_op_pkg.sv
verilog/fm_cmd_if.sv
verilog/fp16_add.sv
verilog/fm_cmd_decode.sv
verilog/fm_accum_exec.sv
verilog/fm_read_result.sv
verilog/fm_accum_top.sv
sim/fm_accum_sva.sv
sim/fm_accum_tb.sv

// File: sim/fm_accum_sva.sv
`timescale 1ns/100ps

module fm_accum_sva import cnn_cfg_pkg::*; (
	input logic                 clk,
	input logic                 rst_n_i,
	input logic                 ena_w_i,
	input logic                 ena_add_write_i,
	input logic                 ena_r_i,
	input logic                 write_ready_o,
	input logic                 rd_valid_o,
	input logic [ROW_WIDTH-1:0] dout_o
);

	int fail_cnt = 0; // assertion failures seen so far

	// read sampled at edge N, rd_valid_o set by edge N+2 and seen at N+3
	assert property (@(posedge clk) disable iff (!rst_n_i) ena_r_i |-> ##3 rd_valid_o)
		else begin
			$error("rd_valid_o did not follow a read");
			fail_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i) rd_valid_o |-> $past(ena_r_i, 3))
		else begin
			$error("rd_valid_o pulsed without a read");
			fail_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		ena_w_i && write_ready_o && !ena_add_write_i |=> !write_ready_o ##1 write_ready_o)
		else begin
			$error("write_ready_o wrong after a store");
			fail_cnt++;
		end

	// accumulate needs a fetch and a commit cycle
	assert property (@(posedge clk) disable iff (!rst_n_i)
		ena_w_i && write_ready_o && ena_add_write_i |=>
			!write_ready_o ##1 !write_ready_o ##1 write_ready_o)
		else begin
			$error("write_ready_o wrong after an accumulate");
			fail_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown({write_ready_o, rd_valid_o, dout_o}))
		else begin
			$error("unknown value on a top-level output");
			fail_cnt++;
		end

endmodule

bind fm_accum_top fm_accum_sva sva0 (.*);

// File: sim/fm_accum_tb.sv
`timescale 1ns/100ps

module fm_accum_tb import cnn_cfg_pkg::*; ();

	localparam int WAIT_LIMIT = 20; // cycles before a wait gives up

	logic                  clk = 1'b0;
	logic                  rst_n_i;
	logic                  ena_w_i;
	logic                  ena_add_write_i;
	logic [ROW_ADDR_W-1:0] addr_write_i;
	logic [ROW_WIDTH-1:0]  din_i;
	logic                  ena_r_i;
	logic [ROW_ADDR_W-1:0] addr_read_i;
	logic [SUB_ADDR_W-1:0] sub_addr_read_i;
	logic                  write_ready_o;
	logic [ROW_WIDTH-1:0]  dout_o;
	logic                  rd_valid_o;

	logic [ROW_WIDTH-1:0]  model [FM_ROWS] = '{default: '0}; // mirror of the buffer
	logic [ROW_WIDTH-1:0]  exp_q [$];                        // reads in flight
	logic [ROW_ADDR_W-1:0] used [8];
	logic [ROW_WIDTH-1:0]  row;
	logic [15:0]           lfsr = 16'd96;
	int                    value_errs = 0;
	int                    timeout_errs = 0;

	always #4 clk = ~clk;

	fm_accum_top dut0 (.*);

	// galois lfsr, stepped once for every bit handed out
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int half_to_int(logic [15:0] h);
		int m;
		if (h[14:10] == 5'd0)
			return 0;
		m = (1024 + int'(h[9:0])) >> (25 - int'(h[14:10])); // integers only, so exp >= 15
		return h[15] ? -m : m;
	endfunction

	function automatic logic [15:0] int_to_half(int v);
		int          m;
		int          p;
		logic [15:0] h;
		m = (v < 0) ? -v : v;
		h = '0;
		if (m != 0) begin
			p        = $clog2(m + 1) - 1; // msb position
			h[15]    = (v < 0);
			h[14:10] = 5'(15 + p);
			h[9:0]   = 10'(m << (10 - p)); // hidden bit drops off the top
		end
		return h;
	endfunction

	function automatic logic [15:0] lane_sum(logic [15:0] a, logic [15:0] b);
		if (a == 16'h7C00 || b == 16'h7C00)
			return 16'h7C00; // only +inf is ever used as an operand
		return int_to_half(half_to_int(a) + half_to_int(b));
	endfunction

	// small integers from -8 to 7, so every sum stays exact
	function automatic logic [ROW_WIDTH-1:0] random_row();
		logic [ROW_WIDTH-1:0] r;
		int                   v;
		for (int l = 0; l < PARA_Y; l++) begin
			v = int'(take_bits(4));
			if (v > 7)
				v = v - 16;
			r[l*DATA_WIDTH +: DATA_WIDTH] = int_to_half(v);
		end
		return r;
	endfunction

	// element j of the result is element j+sub of the row pair, next row wraps
	function automatic logic [ROW_WIDTH-1:0] expected_read(logic [ROW_ADDR_W-1:0] addr, int sub);
		logic [ROW_WIDTH-1:0] r;
		int                   e;
		for (int j = 0; j < PARA_Y; j++) begin
			e = j + sub;
			if (e < PARA_Y)
				r[j*DATA_WIDTH +: DATA_WIDTH] = model[addr][e*DATA_WIDTH +: DATA_WIDTH];
			else
				r[j*DATA_WIDTH +: DATA_WIDTH] =
					model[(int'(addr) + 1) % FM_ROWS][(e-PARA_Y)*DATA_WIDTH +: DATA_WIDTH];
		end
		return r;
	endfunction

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!write_ready_o && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (write_ready_o) else begin
			$display("write_ready_o stayed low for %0d cycles at %0t", WAIT_LIMIT, $time);
			timeout_errs++;
		end
	endtask

	task automatic write_row(logic [ROW_ADDR_W-1:0] addr, logic [ROW_WIDTH-1:0] data, logic acc);
		wait_ready();
		@(posedge clk);
		ena_w_i         <= 1'b1;
		ena_add_write_i <= acc;
		addr_write_i    <= addr;
		din_i           <= data;
		for (int l = 0; l < PARA_Y; l++)
			if (acc)
				model[addr][l*DATA_WIDTH +: DATA_WIDTH] = lane_sum(
					model[addr][l*DATA_WIDTH +: DATA_WIDTH], data[l*DATA_WIDTH +: DATA_WIDTH]);
		if (!acc)
			model[addr] = data;
		@(posedge clk);
		ena_w_i <= 1'b0;
	endtask

	// leaves ena_r_i high so reads can follow on consecutive cycles
	task automatic read_row(logic [ROW_ADDR_W-1:0] addr, int sub);
		wait_ready();
		@(posedge clk);
		ena_r_i         <= 1'b1;
		addr_read_i     <= addr;
		sub_addr_read_i <= SUB_ADDR_W'(sub);
		exp_q.push_back(expected_read(addr, sub));
	endtask

	task automatic finish_reads();
		int n;
		n = 0;
		@(posedge clk);
		ena_r_i <= 1'b0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d reads got no rd_valid_o pulse within %0d cycles", exp_q.size(), n);
			timeout_errs++;
			exp_q.delete();
		end
	endtask

	always @(negedge clk) begin
		if (rst_n_i && rd_valid_o) begin
			assert (exp_q.size() != 0) else begin
				$display("rd_valid_o pulsed at %0t with no read outstanding", $time);
				value_errs++;
			end
			if (exp_q.size() != 0) begin
				assert (dout_o === exp_q[0]) else begin
					$display("[FAIL] %0t dout_o got %h expected %h", $time, dout_o, exp_q[0]);
					value_errs++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		rst_n_i         = 1'b0;
		ena_w_i         = 1'b0;
		ena_add_write_i = 1'b0;
		addr_write_i    = '0;
		din_i           = '0;
		ena_r_i         = 1'b0;
		addr_read_i     = '0;
		sub_addr_read_i = '0;
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		assert (write_ready_o === 1'b1) else begin
			$display("[FAIL] %0t write_ready_o got %b expected 1", $time, write_ready_o);
			value_errs++;
		end
		assert (rd_valid_o === 1'b0) else begin
			$display("[FAIL] %0t rd_valid_o got %b expected 0", $time, rd_valid_o);
			value_errs++;
		end

		for (int i = 0; i < 4; i++)
			read_row(6'(take_bits(6)), int'(take_bits(2))); // empty buffer reads zero
		finish_reads();

		for (int i = 0; i < 8; i++) begin
			used[i] = 6'(take_bits(6));
			write_row(used[i], random_row(), 1'b0);
		end
		write_row(6'd63, random_row(), 1'b0);
		write_row(6'd0, random_row(), 1'b0);
		for (int i = 0; i < 8; i++)
			read_row(used[i], 0);
		finish_reads();

		for (int i = 0; i < 4; i++)
			write_row(used[i], random_row(), 1'b1);
		write_row(used[4], model[used[4]] ^ {PARA_Y{16'h8000}}, 1'b1); // x plus -x
		row = random_row();
		row[2*DATA_WIDTH +: DATA_WIDTH] = 16'h7C00;
		write_row(used[5], row, 1'b1);
		for (int i = 0; i < 8; i++)
			read_row(used[i], 0);
		finish_reads();

		for (int s = 1; s < PARA_Y; s++)
			read_row(6'd63, s); // high row wraps to row 0
		for (int i = 0; i < 6; i++)
			read_row(used[i], i % 3 + 1);
		finish_reads();

		// store offered while an accumulate holds write_ready_o low
		write_row(used[0], random_row(), 1'b1);
		ena_w_i         <= 1'b1;
		ena_add_write_i <= 1'b0;
		addr_write_i    <= used[1];
		din_i           <= random_row();
		repeat (2) @(posedge clk);
		ena_w_i <= 1'b0;
		read_row(used[0], 0);
		read_row(used[1], 0);
		finish_reads();

		for (int i = 0; i < 6; i++)
			read_row(6'(take_bits(6)), int'(take_bits(2)));
		finish_reads();

		$display("errors: value %0d, timeout %0d, assertion %0d",
			value_errs, timeout_errs, dut0.sva0.fail_cnt);
		if (value_errs + timeout_errs + dut0.sva0.fail_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verilog/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

	// buffer geometry
	localparam int DATA_WIDTH = 16; // one binary16 element
	localparam int PARA_Y     = 4;  // elements per row
	localparam int FM_ROWS    = 64;

	localparam int ROW_ADDR_W = $clog2(FM_ROWS);
	localparam int SUB_ADDR_W = $clog2(PARA_Y); // element offset inside a row
	localparam int ROW_WIDTH  = PARA_Y * DATA_WIDTH;

	// binary16 field layout
	localparam int EXP_WIDTH  = 5;
	localparam int FRAC_WIDTH = 10;

	localparam logic [EXP_WIDTH-1:0]  EXP_MAX   = '1;        // inf and nan exponent
	localparam logic [DATA_WIDTH-1:0] FP16_QNAN = 16'h7E00;  // canonical quiet nan

endpackage

// File: verilog/fm_accum_exec.sv
`timescale 1ns/100ps

module fm_accum_exec import cnn_cfg_pkg::*, fm_op_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,

	fm_cmd_if.exec_mp             cmd,

	output logic [ROW_WIDTH-1:0]  fetch_lo_o,
	output logic [ROW_WIDTH-1:0]  fetch_hi_o,
	output logic                  fetch_valid_o,
	output logic [SUB_ADDR_W-1:0] fetch_sub_o
);

	// FM_ROWS rows of PARA_Y elements, all zero at power up
	logic [ROW_WIDTH-1:0]  mem [FM_ROWS] = '{default: '0};

	fm_seq_e               seq_q;
	fm_seq_e               seq;
	logic [ROW_WIDTH-1:0]  old_row_q;
	logic [ROW_WIDTH-1:0]  opnd_q;
	logic [ROW_ADDR_W-1:0] acc_row_q;
	logic [ROW_WIDTH-1:0]  sum_row;

	logic                  mem_we;
	logic [ROW_ADDR_W-1:0] mem_waddr;
	logic [ROW_WIDTH-1:0]  mem_wdata;
	logic [ROW_ADDR_W-1:0] rd_row_nxt;

	for (genvar l = 0; l < PARA_Y; l++) begin : g_lane
		fp16_add u_add (
			.a_i   (old_row_q[l*DATA_WIDTH +: DATA_WIDTH]),
			.b_i   (opnd_q[l*DATA_WIDTH +: DATA_WIDTH]),
			.sum_o (sum_row[l*DATA_WIDTH +: DATA_WIDTH])
		);
	end

	// the fetch phase is the cycle in which decode presents an accumulate,
	// so only the commit phase needs a register of its own
	always_comb begin
		if (seq_q == SEQ_COMMIT)
			seq = SEQ_COMMIT;
		else if (cmd.wr_op == FM_OP_ACCUM)
			seq = SEQ_FETCH;
		else
			seq = SEQ_IDLE;
	end

	assign cmd.busy = (seq == SEQ_FETCH);

	always_comb begin
		mem_we    = 1'b0;
		mem_waddr = cmd.wr_row;
		mem_wdata = cmd.wr_data;
		if (seq == SEQ_COMMIT) begin
			mem_we    = 1'b1;
			mem_waddr = acc_row_q;
			mem_wdata = sum_row; // lane sums from the adders
		end else if (cmd.wr_op == FM_OP_STORE) begin
			mem_we = 1'b1;
		end
	end

	assign rd_row_nxt = cmd.rd_row + ROW_ADDR_W'(1); // last row wraps to row 0

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			seq_q         <= SEQ_IDLE;
			fetch_valid_o <= 1'b0;
		end else begin
			seq_q         <= (seq == SEQ_FETCH) ? SEQ_COMMIT : SEQ_IDLE;
			fetch_valid_o <= cmd.rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_waddr] <= mem_wdata;
		if (seq == SEQ_FETCH) begin
			old_row_q <= mem[cmd.wr_row];
			opnd_q    <= cmd.wr_data;
			acc_row_q <= cmd.wr_row;
		end
		// reads see the contents from before this edge's write
		if (cmd.rd_en) begin
			fetch_lo_o  <= mem[cmd.rd_row];
			fetch_hi_o  <= mem[rd_row_nxt];
			fetch_sub_o <= cmd.rd_sub;
		end
	end

endmodule

// File: verilog/fm_accum_top.sv
`timescale 1ns/100ps

module fm_accum_top import cnn_cfg_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,

	input  logic                  ena_w_i,
	input  logic                  ena_add_write_i,
	input  logic [ROW_ADDR_W-1:0] addr_write_i,
	input  logic [ROW_WIDTH-1:0]  din_i,

	input  logic                  ena_r_i,
	input  logic [ROW_ADDR_W-1:0] addr_read_i,
	input  logic [SUB_ADDR_W-1:0] sub_addr_read_i,

	output logic                  write_ready_o,
	output logic [ROW_WIDTH-1:0]  dout_o,
	output logic                  rd_valid_o
);

	fm_cmd_if cmd_if ();

	logic [ROW_WIDTH-1:0]  fetch_lo;
	logic [ROW_WIDTH-1:0]  fetch_hi;
	logic                  fetch_valid;
	logic [SUB_ADDR_W-1:0] fetch_sub;

	fm_cmd_decode u_decode (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.ena_w_i         (ena_w_i),
		.ena_add_write_i (ena_add_write_i),
		.addr_write_i    (addr_write_i),
		.din_i           (din_i),
		.ena_r_i         (ena_r_i),
		.addr_read_i     (addr_read_i),
		.sub_addr_read_i (sub_addr_read_i),
		.write_ready_o   (write_ready_o),
		.cmd             (cmd_if.decode_mp)
	);

	fm_accum_exec u_exec (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cmd           (cmd_if.exec_mp),
		.fetch_lo_o    (fetch_lo),
		.fetch_hi_o    (fetch_hi),
		.fetch_valid_o (fetch_valid),
		.fetch_sub_o   (fetch_sub)
	);

	fm_read_result u_result (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.fetch_lo_i    (fetch_lo),
		.fetch_hi_i    (fetch_hi),
		.fetch_valid_i (fetch_valid),
		.fetch_sub_i   (fetch_sub),
		.dout_o        (dout_o),
		.rd_valid_o    (rd_valid_o)
	);

endmodule

// File: verilog/fm_cmd_decode.sv
`timescale 1ns/100ps

module fm_cmd_decode import cnn_cfg_pkg::*, fm_op_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,

	input  logic                  ena_w_i,
	input  logic                  ena_add_write_i,
	input  logic [ROW_ADDR_W-1:0] addr_write_i,
	input  logic [ROW_WIDTH-1:0]  din_i,

	input  logic                  ena_r_i,
	input  logic [ROW_ADDR_W-1:0] addr_read_i,
	input  logic [SUB_ADDR_W-1:0] sub_addr_read_i,

	output logic                  write_ready_o,
	fm_cmd_if.decode_mp           cmd
);

	logic   wr_accept;
	fm_op_e wr_op_d;
	fm_op_e rd_op_d;

	assign wr_accept = ena_w_i & write_ready_o; // writes while not ready are dropped here

	always_comb begin
		wr_op_d = FM_OP_NONE;
		if (wr_accept)
			wr_op_d = ena_add_write_i ? FM_OP_ACCUM : FM_OP_STORE;
	end

	assign rd_op_d = ena_r_i ? FM_OP_READ : FM_OP_NONE;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cmd.wr_op     <= FM_OP_NONE;
			cmd.rd_en     <= 1'b0;
			write_ready_o <= 1'b1;
		end else begin
			cmd.wr_op <= wr_op_d; // one cycle only
			cmd.rd_en <= (rd_op_d == FM_OP_READ);
			if (wr_accept)
				write_ready_o <= 1'b0;
			else if (!cmd.busy)
				write_ready_o <= 1'b1;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			cmd.wr_row  <= addr_write_i;
			cmd.wr_data <= din_i;
		end
		if (ena_r_i) begin
			cmd.rd_row <= addr_read_i;
			cmd.rd_sub <= sub_addr_read_i;
		end
	end

endmodule

// File: verilog/fm_cmd_if.sv
`timescale 1ns/100ps

interface fm_cmd_if import cnn_cfg_pkg::*, fm_op_pkg::*; ();

	// write side, held for exactly one cycle per accepted write
	fm_op_e                  wr_op;
	logic [ROW_ADDR_W-1:0]   wr_row;
	logic [ROW_WIDTH-1:0]    wr_data;

	// read side, independent of the write side
	logic                    rd_en;
	logic [ROW_ADDR_W-1:0]   rd_row;
	logic [SUB_ADDR_W-1:0]   rd_sub;

	logic                    busy; // accumulate still reading its row

	modport decode_mp (
		output wr_op, wr_row, wr_data,
		output rd_en, rd_row, rd_sub,
		input  busy
	);

	modport exec_mp (
		input  wr_op, wr_row, wr_data,
		input  rd_en, rd_row, rd_sub,
		output busy
	);

endinterface

// File: verilog/fm_op_pkg.sv
package fm_op_pkg;

	// write opcodes, plus the read marker used by decode
	typedef enum logic [1:0] {
		FM_OP_NONE,
		FM_OP_STORE,
		FM_OP_ACCUM,
		FM_OP_READ
	} fm_op_e;

	// accumulate sequencer phases in execute
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_COMMIT
	} fm_seq_e;

endpackage

// File: verilog/fm_read_result.sv
`timescale 1ns/100ps

module fm_read_result import cnn_cfg_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,

	input  logic [ROW_WIDTH-1:0]  fetch_lo_i,
	input  logic [ROW_WIDTH-1:0]  fetch_hi_i,
	input  logic                  fetch_valid_i,
	input  logic [SUB_ADDR_W-1:0] fetch_sub_i,

	output logic [ROW_WIDTH-1:0]  dout_o,
	output logic                  rd_valid_o
);

	logic [2*ROW_WIDTH-1:0] pair;
	logic [ROW_WIDTH-1:0]   sel;

	// low row holds elements 0 to PARA_Y-1 of the pair
	assign pair = {fetch_hi_i, fetch_lo_i};

	// element j of the result is element j+sub of the pair
	assign sel = pair[fetch_sub_i*DATA_WIDTH +: ROW_WIDTH];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dout_o     <= '0;
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= fetch_valid_i; // single cycle pulse per read
			if (fetch_valid_i)
				dout_o <= sel; // holds between reads
		end
	end

endmodule

// File: verilog/fp16_add.sv
`timescale 1ns/100ps

module fp16_add import cnn_cfg_pkg::*; (
	input  logic [DATA_WIDTH-1:0] a_i,
	input  logic [DATA_WIDTH-1:0] b_i,
	output logic [DATA_WIDTH-1:0] sum_o
);

	logic                  sa, sb;
	logic [EXP_WIDTH-1:0]  ea, eb;
	logic [FRAC_WIDTH-1:0] fa, fb;
	logic                  a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic                  a_big, sub_op, sl;
	logic [EXP_WIDTH-1:0]  el, es, diff;
	logic [FRAC_WIDTH:0]   ml, ms;       // hidden bit restored
	logic [27:0]           sh;           // smaller mantissa after alignment
	logic [14:0]           l_ext, s_ext; // carry, 11 mantissa bits, guard, round, sticky
	logic [14:0]           raw;
	logic [3:0]            lz;
	logic [13:0]           norm;
	logic signed [6:0]     exp_n;
	logic                  rnd_up;
	logic [11:0]           mant_r;

	assign {sa, ea, fa} = a_i;
	assign {sb, eb, fb} = b_i;

	assign a_nan  = (ea == EXP_MAX) && (fa != '0);
	assign b_nan  = (eb == EXP_MAX) && (fb != '0);
	assign a_inf  = (ea == EXP_MAX) && (fa == '0);
	assign b_inf  = (eb == EXP_MAX) && (fb == '0);
	assign a_zero = (ea == '0); // subnormals read as zero
	assign b_zero = (eb == '0);

	// order operands by magnitude so the difference is never negative
	assign a_big  = {ea, fa} >= {eb, fb};
	assign sl     = a_big ? sa : sb;
	assign el     = a_big ? ea : eb;
	assign es     = a_big ? eb : ea;
	assign ml     = a_big ? {1'b1, fa} : {1'b1, fb};
	assign ms     = a_big ? {1'b1, fb} : {1'b1, fa};
	assign diff   = el - es;
	assign sub_op = sa ^ sb;

	always_comb begin
		// past 16 places every bit lands in the sticky part anyway
		sh    = {ms, 17'd0} >> ((diff > 5'd16) ? 5'd16 : diff);
		l_ext = {1'b0, ml, 3'b000};
		s_ext = {1'b0, sh[27:15], sh[14] | (|sh[13:0])};
		raw   = sub_op ? (l_ext - s_ext) : (l_ext + s_ext);

		lz = '0;
		for (int k = 0; k < 14; k++) begin
			if (raw[k])
				lz = 4'(13 - k); // highest set bit wins
		end

		if (raw[14]) begin // carry out, shift right and keep sticky
			norm  = {raw[14:2], raw[1] | raw[0]};
			exp_n = {2'b00, el} + 7'sd1;
		end else begin
			norm  = raw[13:0] << lz;
			exp_n = {2'b00, el} - {3'b000, lz};
		end

		// nearest even on guard, round and sticky
		rnd_up = norm[2] & (norm[1] | norm[0] | norm[3]);
		mant_r = {1'b0, norm[13:3]} + {11'd0, rnd_up};
		if (mant_r[11]) begin
			exp_n  = exp_n + 7'sd1;
			mant_r = mant_r >> 1;
		end

		if (a_nan || b_nan || (a_inf && b_inf && sub_op))
			sum_o = FP16_QNAN;
		else if (a_inf || b_inf)
			sum_o = a_inf ? a_i : b_i;
		else if (a_zero && b_zero)
			sum_o = {sa & sb, 15'd0}; // -0 only when both are negative
		else if (a_zero)
			sum_o = b_i;
		else if (b_zero)
			sum_o = a_i;
		else if (raw == '0)
			sum_o = '0; // exact cancellation gives +0
		else if (exp_n < 7'sd1)
			sum_o = {sl, 15'd0}; // underflow flushed
		else if (exp_n > 7'sd30)
			sum_o = {sl, EXP_MAX, {FRAC_WIDTH{1'b0}}};
		else
			sum_o = {sl, exp_n[EXP_WIDTH-1:0], mant_r[FRAC_WIDTH-1:0]};
	end

endmodule
